//--- Bender.yml
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - pipe_if.sv
  - alu_unit.sv
  - shift_unit.sv
  - instr_fetch.sv
  - decode_stage.sv
  - execute_stage.sv
  - mem_stage.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_cpu_core.sv

//--- alu_unit.sv
module alu_unit (
  input  logic [cpu_pkg::op_w-1:0]   opcode,
  input  logic [cpu_pkg::word_w-1:0] a,
  input  logic [cpu_pkg::word_w-1:0] b,
  output logic [cpu_pkg::word_w-1:0] result
);
  import cpu_pkg::*;

  logic [word_w-1:0] sum;
  logic [word_w-1:0] diff;

  // both wrap modulo 2^16
  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (opcode)
      op_sub: begin
        result = diff;
      end
      op_xor: begin
        result = a ^ b;
      end
      op_and: begin
        result = a & b;
      end
      // a is the old destination, b holds imm8 in its low byte
      op_llb: begin
        result = {a[word_w-1:8], b[7:0]};
      end
      op_lhb: begin
        result = {b[7:0], a[7:0]};
      end
      // add, and the base plus offset of lw and sw
      default: begin
        result = sum;
      end
    endcase
  end

endmodule

//--- cpu_core.f
cpu_pkg.sv
pipe_if.sv
alu_unit.sv
shift_unit.sv
instr_fetch.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
cpu_core.sv
tb_cpu_core.sv

//--- cpu_core.sv
module cpu_core #(
  parameter int imem_aw = cpu_pkg::imem_aw_default,
  parameter int dmem_aw = cpu_pkg::dmem_aw_default
) (
  input  logic                         clk,
  input  logic                         reset,
  // program load port, used while reset is held
  input  logic                         imem_we,
  input  logic [imem_aw-1:0]           imem_addr,
  input  cpu_pkg::instr_t              imem_wdata,
  output logic [cpu_pkg::word_w-1:0]   pc,
  output logic                         hlt,
  // committed register writes
  output logic                         wb_valid,
  output logic [cpu_pkg::reg_id_w-1:0] wb_rd,
  output logic [cpu_pkg::word_w-1:0]   wb_data
);
  import cpu_pkg::*;

  // fetch to decode
  instr_t            if_instr;
  logic [word_w-1:0] if_pc_next;
  logic              if_valid;
  // decode back to fetch
  logic              halt_seen;

  ex_if  ex_bus ();
  mem_if mem_bus ();
  wb_if  wb_bus ();

  instr_fetch #(.imem_aw(imem_aw)) u_fetch (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .halt_seen  (halt_seen),
    .pc         (pc),
    .instr      (if_instr),
    .pc_next    (if_pc_next),
    .fetch_valid(if_valid)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .instr      (if_instr),
    .pc_next    (if_pc_next),
    .fetch_valid(if_valid),
    .halt_seen  (halt_seen),
    .ex         (ex_bus.source),
    .wb         (wb_bus.sink)
  );

  execute_stage u_execute (
    .clk  (clk),
    .reset(reset),
    .ex   (ex_bus.sink),
    .mem  (mem_bus.source),
    .wb   (wb_bus.sink)
  );

  mem_stage #(.dmem_aw(dmem_aw)) u_mem (
    .clk  (clk),
    .reset(reset),
    .mem  (mem_bus.sink),
    .wb   (wb_bus.source)
  );

  // trace and halt straight from the writeback register
  assign hlt      = wb_bus.hlt;
  assign wb_valid = wb_bus.we;
  assign wb_rd    = wb_bus.rd;
  assign wb_data  = wb_bus.data;

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  // datapath, register index and opcode widths
  localparam int word_w   = 16;
  localparam int reg_id_w = 4;
  localparam int op_w     = 4;
  // shift amount spans one full word
  localparam int shamt_w  = $clog2(word_w);

  // default word-address widths of program and data memory
  localparam int imem_aw_default = 8;
  localparam int dmem_aw_default = 8;

  // register arithmetic and logic
  localparam logic [op_w-1:0] op_add = 4'b0000;
  localparam logic [op_w-1:0] op_sub = 4'b0001;
  localparam logic [op_w-1:0] op_xor = 4'b0010;
  localparam logic [op_w-1:0] op_and = 4'b0011;

  // immediate shifts
  localparam logic [op_w-1:0] op_sll = 4'b0100;
  localparam logic [op_w-1:0] op_sra = 4'b0101;
  localparam logic [op_w-1:0] op_ror = 4'b0110;

  // memory and byte loads
  localparam logic [op_w-1:0] op_lw  = 4'b1000;
  localparam logic [op_w-1:0] op_sw  = 4'b1001;
  localparam logic [op_w-1:0] op_llb = 4'b1010;
  localparam logic [op_w-1:0] op_lhb = 4'b1011;

  // pc save and halt, any code not listed is a no-op
  localparam logic [op_w-1:0] op_pcs = 4'b1110;
  localparam logic [op_w-1:0] op_hlt = 4'b1111;

  // register, shift and memory layout
  typedef struct packed {
    logic [op_w-1:0]     opcode;
    logic [reg_id_w-1:0] rd;
    logic [reg_id_w-1:0] rs;
    logic [reg_id_w-1:0] rt;
  } r_form_t;

  // byte-load layout with an 8-bit immediate
  typedef struct packed {
    logic [op_w-1:0]     opcode;
    logic [reg_id_w-1:0] rd;
    logic [7:0]          imm8;
  } i_form_t;

  // one instruction word, decoded through either layout
  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
  } instr_t;

endpackage

//--- decode_stage.sv
module decode_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  cpu_pkg::instr_t            instr,
  input  logic [cpu_pkg::word_w-1:0] pc_next,
  input  logic                       fetch_valid,
  output logic                       halt_seen,
  ex_if.source                       ex,
  wb_if.sink                         wb
);
  import cpu_pkg::*;

  logic [word_w-1:0]   regs [2**reg_id_w];
  logic [op_w-1:0]     opcode;
  logic [reg_id_w-1:0] rd;
  logic [reg_id_w-1:0] rs_id;
  logic [reg_id_w-1:0] rt_id;
  logic [word_w-1:0]   rs_data;
  logic [word_w-1:0]   rt_data;
  logic [word_w-1:0]   imm;
  logic                is_mem;
  logic                is_shift;
  logic                is_byte_load;
  logic                writes_reg;
  logic                halt_q;
  logic                id_valid;

  // both views share opcode and rd
  assign opcode = instr.r_form.opcode;
  assign rd     = instr.r_form.rd;

  assign is_mem       = (opcode == op_lw) || (opcode == op_sw);
  assign is_shift     = opcode inside {op_sll, op_sra, op_ror};
  assign is_byte_load = (opcode == op_llb) || (opcode == op_lhb);
  assign writes_reg   = opcode inside {op_add, op_sub, op_xor, op_and, op_sll, op_sra,
                                       op_ror, op_lw, op_llb, op_lhb, op_pcs};

  // stores carry their data register in the rd field
  assign rt_id = (opcode == op_sw) ? rd : instr.r_form.rt;
  // byte loads read the register they modify
  assign rs_id = is_byte_load ? rd : instr.r_form.rs;

  always_comb begin
    if (is_mem) begin
      // signed word offset, shifted to a byte offset
      imm = {{(word_w-5){instr.r_form.rt[3]}}, instr.r_form.rt, 1'b0};
    end else if (is_shift) begin
      imm = {{(word_w-4){1'b0}}, instr.r_form.rt};
    end else if (is_byte_load) begin
      imm = {{(word_w-8){1'b0}}, instr.i_form.imm8};
    end else begin
      imm = '0;
    end
  end

  // read with write-through from writeback, r0 reads zero
  always_comb begin
    rs_data = regs[rs_id];
    if (wb.we && (wb.rd == rs_id)) begin
      rs_data = wb.data;
    end
    if (rs_id == '0) begin
      rs_data = '0;
    end
    rt_data = regs[rt_id];
    if (wb.we && (wb.rd == rt_id)) begin
      rt_data = wb.data;
    end
    if (rt_id == '0) begin
      rt_data = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_id_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // halt_seen goes high in the cycle hlt sits in decode
  assign halt_seen = halt_q || (fetch_valid && (opcode == op_hlt));
  // bubbles once the halt has gone by
  assign id_valid  = fetch_valid && !halt_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_q       <= 1'b0;
      ex.valid     <= 1'b0;
      ex.reg_write <= 1'b0;
      ex.mem_read  <= 1'b0;
      ex.mem_write <= 1'b0;
      ex.is_hlt    <= 1'b0;
    end else begin
      halt_q       <= halt_seen;
      ex.valid     <= id_valid;
      // r0 is never written
      ex.reg_write <= id_valid && writes_reg && (rd != '0);
      ex.mem_read  <= id_valid && (opcode == op_lw);
      ex.mem_write <= id_valid && (opcode == op_sw);
      ex.is_hlt    <= id_valid && (opcode == op_hlt);
    end
  end

  // decode/execute payload
  always_ff @(posedge clk) begin
    ex.opcode       <= opcode;
    ex.rd           <= rd;
    ex.rs_id        <= rs_id;
    ex.rt_id        <= rt_id;
    ex.rs_data      <= rs_data;
    ex.rt_data      <= rt_data;
    ex.imm          <= imm;
    ex.pc_next      <= pc_next;
    ex.use_imm      <= is_mem;
    ex.is_shift     <= is_shift;
    ex.is_byte_load <= is_byte_load;
    ex.is_pcs       <= (opcode == op_pcs);
  end

  // checked three stages on, where the write really happens
  a_no_r0_write: assert property (@(posedge clk) disable iff (reset) wb.we |-> wb.rd != '0);

endmodule

//--- execute_stage.sv
module execute_stage (
  input logic  clk,
  input logic  reset,
  ex_if.sink   ex,
  mem_if.source mem,
  wb_if.sink   wb
);
  import cpu_pkg::*;

  logic                ex_fwd_we;
  logic [reg_id_w-1:0] ex_fwd_rd;
  logic [word_w-1:0]   ex_fwd_data;
  logic [word_w-1:0]   rs_val;
  logic [word_w-1:0]   rt_val;
  logic [word_w-1:0]   alu_b;
  logic [word_w-1:0]   alu_result;
  logic [word_w-1:0]   shift_result;
  logic [word_w-1:0]   result;

  // the instruction one ahead, now in the memory stage
  // a load there only has its address, so it is skipped
  assign ex_fwd_we   = mem.valid && mem.reg_write && !mem.mem_read;
  assign ex_fwd_rd   = mem.rd;
  assign ex_fwd_data = mem.result;

  // newest producer wins, memory stage before writeback
  function automatic logic [word_w-1:0] fwd_sel(input logic [reg_id_w-1:0] id,
                                                 input logic [word_w-1:0]   rf_val);
    logic [word_w-1:0] val;
    val = rf_val;
    if (wb.we && (wb.rd == id)) begin
      val = wb.data;
    end
    if (ex_fwd_we && (ex_fwd_rd == id)) begin
      val = ex_fwd_data;
    end
    return val;
  endfunction

  always_comb begin
    rs_val = fwd_sel(ex.rs_id, ex.rs_data);
    rt_val = fwd_sel(ex.rt_id, ex.rt_data);
  end

  // memory offset or byte-load immediate replaces rt
  assign alu_b = (ex.use_imm || ex.is_byte_load) ? ex.imm : rt_val;

  alu_unit u_alu (
    .opcode(ex.opcode),
    .a     (rs_val),
    .b     (alu_b),
    .result(alu_result)
  );

  // amount is the raw rt field carried in imm
  shift_unit u_shift (
    .opcode(ex.opcode),
    .a     (rs_val),
    .amount(ex.imm[shamt_w-1:0]),
    .result(shift_result)
  );

  assign result = ex.is_pcs   ? ex.pc_next :
                  ex.is_shift ? shift_result :
                                alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem.valid     <= 1'b0;
      mem.reg_write <= 1'b0;
      mem.mem_read  <= 1'b0;
      mem.mem_write <= 1'b0;
      mem.is_hlt    <= 1'b0;
    end else begin
      mem.valid     <= ex.valid;
      mem.reg_write <= ex.reg_write;
      mem.mem_read  <= ex.mem_read;
      mem.mem_write <= ex.mem_write;
      mem.is_hlt    <= ex.is_hlt;
    end
  end

  // execute/memory payload
  always_ff @(posedge clk) begin
    mem.result     <= result;
    mem.store_data <= rt_val;
    mem.rd         <= ex.rd;
    mem.rt_id      <= ex.rt_id;
  end

endmodule

//--- instr_fetch.sv
module instr_fetch #(
  parameter int imem_aw = cpu_pkg::imem_aw_default
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       imem_we,
  input  logic [imem_aw-1:0]         imem_addr,
  input  cpu_pkg::instr_t            imem_wdata,
  // hlt decoded, stop advancing
  input  logic                       halt_seen,
  output logic [cpu_pkg::word_w-1:0] pc,
  output cpu_pkg::instr_t            instr,
  output logic [cpu_pkg::word_w-1:0] pc_next,
  output logic                       fetch_valid
);
  import cpu_pkg::*;

  instr_t             imem [2**imem_aw];
  logic [imem_aw-1:0] pc_word;
  logic [word_w-1:0]  pc_plus2;

  // byte address to word address
  assign pc_word  = pc[imem_aw:1];
  assign pc_plus2 = pc + word_w'(2);

  // load port, the core is held in reset while it is used
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!halt_seen) begin
      pc <= pc_plus2;
    end
  end

  // fetch/decode register, the slot behind a hlt is dropped here
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= !halt_seen;
    end
  end

  always_ff @(posedge clk) begin
    instr   <= imem[pc_word];
    pc_next <= pc_plus2;
  end

  a_pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

//--- mem_stage.sv
module mem_stage #(
  parameter int dmem_aw = cpu_pkg::dmem_aw_default
) (
  input logic  clk,
  input logic  reset,
  mem_if.sink  mem,
  wb_if.source wb
);
  import cpu_pkg::*;

  logic [word_w-1:0]  dmem [2**dmem_aw];
  logic [dmem_aw-1:0] addr_word;
  logic [word_w-1:0]  store_val;
  logic [word_w-1:0]  load_data;

  // byte address to word address
  assign addr_word = mem.result[dmem_aw:1];

  // memory-to-memory forward, e.g. a lw directly before the sw of its data
  assign store_val = (wb.we && (wb.rd == mem.rt_id)) ? wb.data : mem.store_data;

  assign load_data = dmem[addr_word];

  always_ff @(posedge clk) begin
    if (mem.valid && mem.mem_write) begin
      dmem[addr_word] <= store_val;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb.we  <= 1'b0;
      wb.hlt <= 1'b0;
    end else begin
      wb.we  <= mem.valid && mem.reg_write;
      // sticky until the next reset
      wb.hlt <= wb.hlt || (mem.valid && mem.is_hlt);
    end
  end

  // memory/writeback payload, load data or the execute result
  always_ff @(posedge clk) begin
    wb.rd   <= mem.rd;
    wb.data <= mem.mem_read ? load_data : mem.result;
  end

  // decode sets at most one of the two
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(mem.mem_read && mem.mem_write));

endmodule

//--- pipe_if.sv
// decode to execute bundle
interface ex_if;
  import cpu_pkg::*;

  logic                valid;
  logic [op_w-1:0]     opcode;
  logic [reg_id_w-1:0] rd;
  logic [reg_id_w-1:0] rs_id;
  logic [reg_id_w-1:0] rt_id;
  logic [word_w-1:0]   rs_data;
  logic [word_w-1:0]   rt_data;
  logic [word_w-1:0]   imm;
  logic [word_w-1:0]   pc_next;
  logic                reg_write;
  logic                mem_read;
  logic                mem_write;
  logic                use_imm;
  logic                is_shift;
  logic                is_byte_load;
  logic                is_pcs;
  logic                is_hlt;

  modport source (
    output valid, opcode, rd, rs_id, rt_id, rs_data, rt_data, imm, pc_next,
    output reg_write, mem_read, mem_write, use_imm, is_shift, is_byte_load,
    output is_pcs, is_hlt
  );
  modport sink (
    input valid, opcode, rd, rs_id, rt_id, rs_data, rt_data, imm, pc_next,
    input reg_write, mem_read, mem_write, use_imm, is_shift, is_byte_load,
    input is_pcs, is_hlt
  );
endinterface

// execute to memory bundle
interface mem_if;
  import cpu_pkg::*;

  logic                valid;
  // alu result, or the address for lw and sw
  logic [word_w-1:0]   result;
  logic [word_w-1:0]   store_data;
  logic [reg_id_w-1:0] rd;
  logic [reg_id_w-1:0] rt_id;
  logic                reg_write;
  logic                mem_read;
  logic                mem_write;
  logic                is_hlt;

  modport source (
    output valid, result, store_data, rd, rt_id, reg_write, mem_read, mem_write, is_hlt
  );
  modport sink (
    input valid, result, store_data, rd, rt_id, reg_write, mem_read, mem_write, is_hlt
  );
endinterface

// writeback bundle, fans out to regfile and forwarding
interface wb_if;
  import cpu_pkg::*;

  logic                we;
  logic [reg_id_w-1:0] rd;
  logic [word_w-1:0]   data;
  logic                hlt;

  modport source (output we, rd, data, hlt);
  modport sink (input we, rd, data, hlt);
endinterface

//--- shift_unit.sv
module shift_unit (
  input  logic [cpu_pkg::op_w-1:0]    opcode,
  input  logic [cpu_pkg::word_w-1:0]  a,
  input  logic [cpu_pkg::shamt_w-1:0] amount,
  output logic [cpu_pkg::word_w-1:0]  result
);
  import cpu_pkg::*;

  logic [2*word_w-1:0] ror_wide;

  // rotate as a shift of the word doubled
  assign ror_wide = {a, a} >> amount;

  always_comb begin
    case (opcode)
      op_sll: begin
        result = a << amount;
      end
      op_sra: begin
        // sign bit fills from the left
        result = $signed(a) >>> amount;
      end
      op_ror: begin
        result = ror_wide[word_w-1:0];
      end
      default: begin
        result = a;
      end
    endcase
  end

endmodule

//--- tb_cpu_core.sv
module tb_cpu_core;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  logic              clk;
  logic              reset;
  logic              imem_we;
  logic [7:0]        imem_addr;
  instr_t            imem_wdata;
  logic [word_w-1:0] pc;
  logic              hlt;
  logic              wb_valid;
  logic [3:0]        wb_rd;
  logic [15:0]       wb_data;

  // program under test, shared by loader and reference model
  instr_t      prog [$];
  // expected and observed writeback traces
  logic [3:0]  exp_rd [$];
  logic [15:0] exp_data [$];
  logic [3:0]  got_rd [$];
  logic [15:0] got_data [$];

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  cpu_core u_dut (
    .clk       (clk),
    .reset     (reset),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .pc        (pc),
    .hlt       (hlt),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // next rising edge, then the small drive delay
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[14:0], fb};
    end
    return val;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [15:0] v;
    v = lfsr_bits(8);
    return v[7:0];
  endfunction

  // register, shift and memory encoding
  function automatic instr_t reg_form(input logic [3:0] op, input logic [3:0] rd,
                                      input logic [3:0] rs, input logic [3:0] rt);
    instr_t w;
    w.r_form.opcode = op;
    w.r_form.rd     = rd;
    w.r_form.rs     = rs;
    w.r_form.rt     = rt;
    return w;
  endfunction

  // byte-load encoding
  function automatic instr_t imm_form(input logic [3:0] op, input logic [3:0] rd,
                                      input logic [7:0] imm8);
    instr_t w;
    w.i_form.opcode = op;
    w.i_form.rd     = rd;
    w.i_form.imm8   = imm8;
    return w;
  endfunction

  // shifts one bit position at a time
  function automatic logic [15:0] shift_ref(input logic [3:0] op, input logic [15:0] a,
                                            input logic [3:0] amt);
    logic [15:0] v;
    v = a;
    for (int i = 0; i < amt; i++) begin
      if (op == op_sll) begin
        v = {v[14:0], 1'b0};
      end else if (op == op_sra) begin
        v = {v[15], v[15:1]};
      end else begin
        v = {v[0], v[15:1]};
      end
    end
    return v;
  endfunction

  // instruction-level interpreter, one instruction per step
  task automatic run_model();
    logic [15:0] regs [16];
    logic [15:0] dmem [256];
    logic [15:0] pc_m;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] sext;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    instr_t      w;
    logic        wr;
    bit          done;
    int          steps;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = '0;
    end
    exp_rd.delete();
    exp_data.delete();
    pc_m  = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
      // running off the program end counts as a halt
      if (int'(pc_m[15:1]) >= prog.size()) begin
        done = 1'b1;
      end else begin
        w  = prog[pc_m[15:1]];
        op = w.r_form.opcode;
        rd = w.r_form.rd;
        rs = w.r_form.rs;
        rt = w.r_form.rt;
        // word offset sign-extended, then scaled to bytes
        sext = {{12{rt[3]}}, rt};
        addr = regs[rs] + (sext << 1);
        wr   = 1'b1;
        res  = '0;
        case (op)
          op_add: res = regs[rs] + regs[rt];
          op_sub: res = regs[rs] - regs[rt];
          op_xor: res = regs[rs] ^ regs[rt];
          op_and: res = regs[rs] & regs[rt];
          op_sll, op_sra, op_ror: res = shift_ref(op, regs[rs], rt);
          op_lw:  res = dmem[addr[8:1]];
          op_sw: begin
            // store data sits in the rd field
            dmem[addr[8:1]] = regs[rd];
            wr = 1'b0;
          end
          op_llb: res = {regs[rd][15:8], w.i_form.imm8};
          op_lhb: res = {w.i_form.imm8, regs[rd][7:0]};
          op_pcs: res = pc_m + 16'd2;
          op_hlt: begin
            wr   = 1'b0;
            done = 1'b1;
          end
          default: wr = 1'b0;
        endcase
        // r0 stays zero and leaves no trace entry
        if (wr && rd != 4'd0) begin
          regs[rd] = res;
          exp_rd.push_back(rd);
          exp_data.push_back(res);
        end
        pc_m = pc_m + 16'd2;
      end
      steps++;
    end
  endtask

  // load under reset, release, record writebacks up to hlt, compare
  task automatic run_program();
    int  cycles;
    bit  halted;
    int  n;
    step();
    reset = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      imem_we    = 1'b1;
      imem_addr  = i[7:0];
      imem_wdata = prog[i];
      step();
    end
    imem_we = 1'b0;
    repeat (10) step();
    reset = 1'b0;
    run_model();
    got_rd.delete();
    got_data.delete();
    halted = 1'b0;
    cycles = 0;
    // sample on the falling edge, well away from register updates
    while (!halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
      if (wb_valid) begin
        got_rd.push_back(wb_rd);
        got_data.push_back(wb_data);
      end
      if (hlt) begin
        halted = 1'b1;
      end
    end
    if (!halted) begin
      errors++;
      $display("the core never halted within 2000 cycles at %0t ns", $time);
    end
    check_value("trace length", exp_rd.size(), got_rd.size());
    n = (exp_rd.size() < got_rd.size()) ? exp_rd.size() : got_rd.size();
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("wb_rd[%0d]", i), exp_rd[i], got_rd[i]);
      check_value($sformatf("wb_data[%0d]", i), exp_data[i], got_data[i]);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  // dependent chains, each operand one or two instructions old
  task automatic arith_forwarding();
    int err_start;
    err_start = errors;
    prog.delete();
    for (int r = 0; r < 2; r++) begin
      prog.push_back(imm_form(op_llb, 4'd1, rand_byte()));
      prog.push_back(imm_form(op_lhb, 4'd1, rand_byte()));
      prog.push_back(imm_form(op_llb, 4'd2, rand_byte()));
      prog.push_back(imm_form(op_lhb, 4'd2, rand_byte()));
      prog.push_back(reg_form(op_add, 4'd3, 4'd1, 4'd2));
      prog.push_back(reg_form(op_sub, 4'd4, 4'd3, 4'd1));
      prog.push_back(reg_form(op_xor, 4'd5, 4'd4, 4'd3));
      prog.push_back(reg_form(op_and, 4'd6, 4'd5, 4'd4));
      prog.push_back(reg_form(op_add, 4'd7, 4'd6, 4'd5));
      prog.push_back(reg_form(op_sub, 4'd8, 4'd2, 4'd7));
      prog.push_back(reg_form(op_xor, 4'd9, 4'd8, 4'd6));
      prog.push_back(reg_form(op_and, 4'd10, 4'd9, 4'd8));
      prog.push_back(reg_form(op_add, 4'd11, 4'd10, 4'd10));
      prog.push_back(reg_form(op_sub, 4'd12, 4'd11, 4'd3));
    end
    prog.push_back(reg_form(op_hlt, 4'd0, 4'd0, 4'd0));
    run_program();
    report_test("arith_forwarding", err_start);
  endtask

  // every amount on a random word and on one with the sign bit set
  task automatic shift_sweep();
    int err_start;
    err_start = errors;
    prog.delete();
    prog.push_back(imm_form(op_llb, 4'd1, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd1, rand_byte()));
    prog.push_back(imm_form(op_llb, 4'd5, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd5, rand_byte() | 8'h80));
    for (int amt = 0; amt < 16; amt++) begin
      prog.push_back(reg_form(op_sll, 4'd2, 4'd1, 4'(amt)));
      prog.push_back(reg_form(op_sra, 4'd3, 4'd1, 4'(amt)));
      prog.push_back(reg_form(op_ror, 4'd4, 4'd1, 4'(amt)));
      prog.push_back(reg_form(op_sra, 4'd6, 4'd5, 4'(amt)));
      prog.push_back(reg_form(op_ror, 4'd7, 4'd5, 4'(amt)));
    end
    prog.push_back(reg_form(op_hlt, 4'd0, 4'd0, 4'd0));
    run_program();
    report_test("shift_sweep", err_start);
  endtask

  task automatic byte_loads();
    int err_start;
    err_start = errors;
    prog.delete();
    prog.push_back(imm_form(op_llb, 4'd1, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd1, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd2, rand_byte()));
    prog.push_back(imm_form(op_llb, 4'd2, rand_byte()));
    prog.push_back(imm_form(op_llb, 4'd3, rand_byte()));
    // rewrite one byte and keep the other
    prog.push_back(imm_form(op_llb, 4'd1, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd2, rand_byte()));
    prog.push_back(reg_form(op_add, 4'd4, 4'd1, 4'd2));
    prog.push_back(reg_form(op_xor, 4'd5, 4'd3, 4'd1));
    prog.push_back(reg_form(op_hlt, 4'd0, 4'd0, 4'd0));
    run_program();
    report_test("byte_loads", err_start);
  endtask

  task automatic store_load();
    int     err_start;
    instr_t nop;
    err_start = errors;
    nop = reg_form(4'b0111, 4'd0, 4'd0, 4'd0);
    prog.delete();
    prog.push_back(imm_form(op_llb, 4'd1, 8'h10));
    prog.push_back(imm_form(op_llb, 4'd2, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd2, rand_byte()));
    prog.push_back(reg_form(op_sw, 4'd2, 4'd1, 4'd0));
    prog.push_back(imm_form(op_llb, 4'd3, rand_byte()));
    prog.push_back(imm_form(op_lhb, 4'd3, rand_byte()));
    prog.push_back(reg_form(op_sw, 4'd3, 4'd1, 4'd1));
    // negative offset, base minus four bytes
    prog.push_back(reg_form(op_sw, 4'd2, 4'd1, 4'he));
    prog.push_back(reg_form(op_lw, 4'd4, 4'd1, 4'd0));
    prog.push_back(reg_form(op_lw, 4'd5, 4'd1, 4'd1));
    prog.push_back(reg_form(op_lw, 4'd6, 4'd1, 4'he));
    // store right behind the load of its data
    prog.push_back(reg_form(op_lw, 4'd7, 4'd1, 4'd1));
    prog.push_back(reg_form(op_sw, 4'd7, 4'd1, 4'd3));
    prog.push_back(nop);
    prog.push_back(reg_form(op_lw, 4'd8, 4'd1, 4'd3));
    prog.push_back(nop);
    prog.push_back(reg_form(op_add, 4'd9, 4'd8, 4'd4));
    prog.push_back(reg_form(op_hlt, 4'd0, 4'd0, 4'd0));
    run_program();
    report_test("store_load", err_start);
  endtask

  task automatic pcs_and_r0();
    int err_start;
    err_start = errors;
    prog.delete();
    prog.push_back(reg_form(op_pcs, 4'd1, 4'd0, 4'd0));
    prog.push_back(reg_form(op_add, 4'd2, 4'd1, 4'd1));
    prog.push_back(reg_form(op_pcs, 4'd3, 4'd0, 4'd0));
    // writes aimed at r0 are dropped
    prog.push_back(reg_form(op_add, 4'd0, 4'd1, 4'd1));
    prog.push_back(imm_form(op_llb, 4'd0, 8'h55));
    prog.push_back(reg_form(op_pcs, 4'd0, 4'd0, 4'd0));
    prog.push_back(reg_form(op_xor, 4'd4, 4'd0, 4'd1));
    prog.push_back(reg_form(op_hlt, 4'd0, 4'd0, 4'd0));
    run_program();
    report_test("pcs_and_r0", err_start);
  endtask

  // instructions behind hlt must never commit
  task automatic halt_hold();
    int          err_start;
    logic [15:0] pc_held;
    err_start = errors;
    prog.delete();
    prog.push_back(imm_form(op_llb, 4'd1, rand_byte()));
    prog.push_back(reg_form(op_add, 4'd2, 4'd1, 4'd1));
    prog.push_back(reg_form(op_pcs, 4'd3, 4'd0, 4'd0));
    // fetch freezes one word past the hlt
    pc_held = 16'(2 * prog.size() + 2);
    prog.push_back(reg_form(op_hlt, 4'd0, 4'd0, 4'd0));
    prog.push_back(imm_form(op_llb, 4'd4, 8'haa));
    prog.push_back(reg_form(op_add, 4'd5, 4'd1, 4'd1));
    prog.push_back(reg_form(op_pcs, 4'd6, 4'd0, 4'd0));
    run_program();
    repeat (20) begin
      @(negedge clk);
      check_value("hlt", 1, hlt);
      check_value("pc", pc_held, pc);
      check_value("wb_valid", 0, wb_valid);
    end
    report_test("halt_hold", err_start);
  endtask

  initial begin
    reset        = 1'b1;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    lfsr_state   = 32'd87352;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    arith_forwarding();
    shift_sweep();
    byte_loads();
    store_load();
    pcs_and_r0();
    halt_hold();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
